/* project.f */
rtl/rvIsaPkg.sv
rtl/fetchCtrlPkg.sv
rtl/fetchUnit.sv
rtl/instBusBridge.sv
rtl/controlFlowResolver.sv
rtl/fetchConfig.sv
rtl/fetchFrontEnd.sv
tb/tbClockGen.sv
tb/fetchFrontEnd_tb.sv

/* run.sh */
#!/bin/sh
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module fetchFrontEnd_tb -f project.f -o simv || exit 1

out="$(./obj_dir/simv 2>&1)"
echo "$out"

echo "$out" | grep -q "^Simulation PASSED$" && exit 0 || exit 1

/* tb/fetchFrontEnd_tb.sv */
// testbench top: memory and register bus models, next-pc reference, stimulus, checks
`timescale 1ns/100ps
`default_nettype none

module fetchFrontEnd_tb;

    localparam rvIsaPkg::addrT DefaultVector = 32'h0000_0000;
    localparam rvIsaPkg::addrT FirstVector   = 32'h0000_0400;
    localparam rvIsaPkg::addrT SecondVector  = 32'h0001_2a80;
    localparam int ItemsPerRun = 150;
    // 300 items at up to about 60 cycles each, plus register traffic
    localparam int MaxCycles = 20000;

    wire clk;
    wire rst;
    logic stall;
    wire memReq;
    wire rvIsaPkg::addrT memAddr;
    logic memAck;
    rvIsaPkg::instT memData;
    logic cfgReq;
    logic cfgWrite;
    fetchCtrlPkg::cfgRegT cfgAddr;
    logic [31:0] cfgWdata;
    wire cfgAck;
    wire [31:0] cfgRdata;
    logic resolveValid;
    logic resolveTaken;
    rvIsaPkg::addrT rs1Value;
    wire decEn;
    wire rvIsaPkg::addrT pc;
    wire rvIsaPkg::instT inst;

    integer seed = 32'h6d52;
    rvIsaPkg::instT progMem [0:1023];
    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;
    int issuedCount = 0;
    rvIsaPkg::addrT expPc = '0;
    logic stallOn = 1'b0;
    logic resolvePending = 1'b0;
    logic resTaken = 1'b0;
    rvIsaPkg::addrT resRs1 = '0;
    int resDelay = 1;
    logic prevStall = 1'b0;
    logic prevDecEn = 1'b0;
    rvIsaPkg::addrT prevPc;
    rvIsaPkg::instT prevInst;

    tbClockGen clockGenInst (
        .clk (clk),
        .rst (rst)
    );

    fetchFrontEnd #(
        .DefaultResetVector (DefaultVector),
        .CountWidth         (16)
    ) fetchFrontEnd_inst (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .memReq       (memReq),
        .memAddr      (memAddr),
        .memAck       (memAck),
        .memData      (memData),
        .cfgReq       (cfgReq),
        .cfgWrite     (cfgWrite),
        .cfgAddr      (cfgAddr),
        .cfgWdata     (cfgWdata),
        .cfgAck       (cfgAck),
        .cfgRdata     (cfgRdata),
        .resolveValid (resolveValid),
        .resolveTaken (resolveTaken),
        .rs1Value     (rs1Value),
        .decEn        (decEn),
        .pc           (pc),
        .inst         (inst)
    );

    // upper address bits fold into the immediates, so aliased words differ
    function automatic rvIsaPkg::instT memWordAt(input rvIsaPkg::addrT a);
        rvIsaPkg::instT w;
        w = progMem[a[11:2]];
        w[31:12] = w[31:12] ^ a[31:12];
        return w;
    endfunction

    // next pc after an issued word, straight from the RV32I encoding
    function automatic rvIsaPkg::addrT refNextPc(
        input rvIsaPkg::addrT curPc,
        input rvIsaPkg::instT w,
        input logic           taken,
        input rvIsaPkg::addrT rs1
    );
        rvIsaPkg::addrT offJ;
        rvIsaPkg::addrT offB;
        rvIsaPkg::addrT offI;
        rvIsaPkg::addrT target;
        offJ = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        offB = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        offI = {{20{w[31]}}, w[31:20]};
        if (!w[6]) begin
            target = curPc + 32'd4;
        end else if (w[6:0] == 7'b1101111) begin
            target = curPc + offJ;
        end else if (w[6:0] == 7'b1100111) begin
            target = rs1 + offI;
            target[0] = 1'b0;
        end else begin
            target = taken ? curPc + offB : curPc + 32'd4;
        end
        return target;
    endfunction

    task automatic addrEqual(input string name, input rvIsaPkg::addrT got,
                             input rvIsaPkg::addrT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic instEqual(input string name, input rvIsaPkg::instT got,
                             input rvIsaPkg::instT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic wordEqual(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    // one four-phase register bus transfer
    task automatic busAccess(input logic write, input fetchCtrlPkg::cfgRegT addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk);
        #2;
        cfgReq   = 1'b1;
        cfgWrite = write;
        cfgAddr  = addr;
        cfgWdata = wdata;
        do @(negedge clk); while (!cfgAck);
        rdata = cfgRdata;
        @(posedge clk);
        #2;
        cfgReq = 1'b0;
        do @(negedge clk); while (cfgAck);
    endtask

    task automatic writeRegister(input fetchCtrlPkg::cfgRegT addr, input logic [31:0] data);
        logic [31:0] ignored;
        busAccess(1'b1, addr, data, ignored);
    endtask

    task automatic readAndCompare(input fetchCtrlPkg::cfgRegT addr, input logic [31:0] exp,
                                  input string name);
        logic [31:0] rd;
        busAccess(1'b0, addr, 32'd0, rd);
        wordEqual(name, rd, exp);
    endtask

    // start at a vector, fetch a batch, stop and check the bus goes quiet
    task automatic runFrom(input rvIsaPkg::addrT vector);
        int quietFails;
        quietFails = 0;
        writeRegister(fetchCtrlPkg::RegResetVec, vector);
        readAndCompare(fetchCtrlPkg::RegResetVec, vector, "resetVector");
        expPc = vector;
        issuedCount = 0;
        writeRegister(fetchCtrlPkg::RegCtrl, 32'd1);
        readAndCompare(fetchCtrlPkg::RegCtrl, 32'd1, "runEnable");
        stallOn = 1'b1;
        while (issuedCount < ItemsPerRun) @(negedge clk);
        stallOn = 1'b0;
        writeRegister(fetchCtrlPkg::RegCtrl, 32'd0);
        // item in flight drains first
        repeat (40) @(negedge clk);
        repeat (100) begin
            @(negedge clk);
            if (memReq) begin
                quietFails++;
            end
        end
        if (quietFails > 0) begin
            errorCount++;
            $display("memReq was raised on %0d cycles after run was cleared", quietFails);
        end
        readAndCompare(fetchCtrlPkg::RegFetchCount, 32'(issuedCount), "fetchCount");
    endtask

    initial begin : stimulus
        stall        = 1'b0;
        memAck       = 1'b0;
        memData      = '0;
        cfgReq       = 1'b0;
        cfgWrite     = 1'b0;
        cfgAddr      = fetchCtrlPkg::RegCtrl;
        cfgWdata     = '0;
        resolveValid = 1'b0;
        resolveTaken = 1'b0;
        rs1Value     = '0;
        // roughly one word in four redirects
        for (int i = 0; i < 1024; i++) begin
            progMem[i] = $random(seed);
            case ({$random(seed)} % 12)
                0:       progMem[i][6:0] = 7'b1101111;
                1:       progMem[i][6:0] = 7'b1100111;
                2:       progMem[i][6:0] = 7'b1100011;
                default: progMem[i][6:0] = 7'b0010011;
            endcase
        end
        wait (rst === 1'b0);
        repeat (2) @(posedge clk);
        readAndCompare(fetchCtrlPkg::RegResetVec, DefaultVector, "resetVector");
        readAndCompare(fetchCtrlPkg::RegCtrl, 32'd0, "runEnable");
        runFrom(FirstVector);
        runFrom(SecondVector);
        $display("checks: %0d, errors: %0d, items in last run: %0d",
                 checkCount, errorCount, issuedCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // expected-item process
    always @(negedge clk) begin : itemMonitor
        logic [31:0] rnd;
        rvIsaPkg::instT expWord;
        if (rst) begin
            prevStall = 1'b0;
        end else begin
            if (prevStall) begin
                if (decEn !== prevDecEn) begin
                    errorCount++;
                    $display("ERROR %0t decEn: got %b expected %b", $time, decEn, prevDecEn);
                end
                addrEqual("pc held", pc, prevPc);
                instEqual("inst held", inst, prevInst);
            end
            if (decEn && !stall) begin
                issuedCount++;
                expWord = memWordAt(expPc);
                addrEqual("pc", pc, expPc);
                instEqual("inst", inst, expWord);
                // branch and jalr need an execute result
                if (expWord[6] && expWord[6:0] != 7'b1101111) begin
                    rnd = $random(seed);
                    resTaken = rnd[0];
                    resDelay = 1 + int'(rnd[2:1]);
                    resRs1 = $random(seed);
                    resolvePending = 1'b1;
                end
                expPc = refNextPc(expPc, expWord, resTaken, resRs1);
            end
            prevStall = stall;
            prevDecEn = decEn;
            prevPc    = pc;
            prevInst  = inst;
        end
    end

    initial begin : resolveDriver
        forever begin
            @(posedge clk);
            if (resolvePending) begin
                resolvePending = 1'b0;
                repeat (resDelay - 1) @(posedge clk);
                #2;
                resolveValid = 1'b1;
                resolveTaken = resTaken;
                rs1Value     = resRs1;
                @(posedge clk);
                #2;
                resolveValid = 1'b0;
            end
        end
    end

    // four-phase memory, 0 to 5 cycles before ack
    initial begin : memoryModel
        int delay;
        forever begin
            @(negedge clk);
            if (memReq && !rst) begin
                // request must be for the next expected item
                addrEqual("memAddr", memAddr, expPc);
                delay = {$random(seed)} % 6;
                repeat (delay) @(posedge clk);
                @(posedge clk);
                #2;
                memData = memWordAt(memAddr);
                memAck  = 1'b1;
                do @(negedge clk); while (memReq);
                @(posedge clk);
                #2;
                memAck = 1'b0;
            end
        end
    end

    always @(posedge clk) begin : stallDriver
        logic [31:0] rnd;
        rnd = $random(seed);
        #2;
        stall = stallOn && (rnd[1:0] == 2'b00);
    end

    always @(posedge clk) begin : watchdog
        cycleCount++;
        if (cycleCount >= MaxCycles) begin
            $display("timeout: run did not finish within %0d cycles", MaxCycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tb/tbClockGen.sv */
// testbench clock and power-on reset source
`timescale 1ns/100ps
`default_nettype none

module tbClockGen #(
    parameter int HalfPeriod  = 10,
    parameter int ResetCycles = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(HalfPeriod) clk = ~clk;
    end

    // release lines up with the 2 ns input skew
    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #2;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* rtl/fetchFrontEnd.sv */
// fetch front end top: fetch FSM, memory bridge, resolver, config block
`timescale 1ns/100ps
`default_nettype none

module fetchFrontEnd #(
    parameter rvIsaPkg::addrT DefaultResetVector = 32'h0,
    parameter int             CountWidth         = 16
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       stall,
    output wire                       memReq,
    output wire rvIsaPkg::addrT       memAddr,
    input  wire                       memAck,
    input  wire rvIsaPkg::instT       memData,
    input  wire                       cfgReq,
    input  wire                       cfgWrite,
    input  wire fetchCtrlPkg::cfgRegT cfgAddr,
    input  wire [31:0]                cfgWdata,
    output wire                       cfgAck,
    output wire [31:0]                cfgRdata,
    input  wire                       resolveValid,
    input  wire                       resolveTaken,
    input  wire rvIsaPkg::addrT       rs1Value,
    output wire                       decEn,
    output wire rvIsaPkg::addrT       pc,
    output wire rvIsaPkg::instT       inst
);

    wire runEnable;
    wire restart;
    wire rvIsaPkg::addrT resetVector;
    wire enJump;
    wire rvIsaPkg::addrT jumpAddr;
    wire enBranch;
    wire rvIsaPkg::addrT branchAddr;
    wire issued;
    wire instEn;
    wire rvIsaPkg::addrT instAddr;
    wire memInstOutEn;
    wire rvIsaPkg::instT memInst;

    fetchUnit fetchUnitInst (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .runEnable    (runEnable),
        .restart      (restart),
        .resetVector  (resetVector),
        .enJump       (enJump),
        .jumpAddr     (jumpAddr),
        .enBranch     (enBranch),
        .branchAddr   (branchAddr),
        .memInstOutEn (memInstOutEn),
        .memInst      (memInst),
        .decEn        (decEn),
        .pc           (pc),
        .inst         (inst),
        .issued       (issued),
        .instEn       (instEn),
        .instAddr     (instAddr)
    );

    instBusBridge instBusBridgeInst (
        .clk          (clk),
        .rst          (rst),
        .instEn       (instEn),
        .instAddr     (instAddr),
        .memAck       (memAck),
        .memData      (memData),
        .memReq       (memReq),
        .memAddr      (memAddr),
        .memInstOutEn (memInstOutEn),
        .memInst      (memInst)
    );

    controlFlowResolver controlFlowResolverInst (
        .clk          (clk),
        .rst          (rst),
        .restart      (restart),
        .issued       (issued),
        .pc           (pc),
        .inst         (inst),
        .resolveValid (resolveValid),
        .resolveTaken (resolveTaken),
        .rs1Value     (rs1Value),
        .enJump       (enJump),
        .jumpAddr     (jumpAddr),
        .enBranch     (enBranch),
        .branchAddr   (branchAddr)
    );

    fetchConfig #(
        .DefaultResetVector (DefaultResetVector),
        .CountWidth         (CountWidth)
    ) fetchConfigInst (
        .clk          (clk),
        .rst          (rst),
        .cfgReq       (cfgReq),
        .cfgWrite     (cfgWrite),
        .cfgAddr      (cfgAddr),
        .cfgWdata     (cfgWdata),
        .issued       (issued),
        .cfgAck       (cfgAck),
        .cfgRdata     (cfgRdata),
        .runEnable    (runEnable),
        .restart      (restart),
        .resetVector  (resetVector)
    );

endmodule

`default_nettype wire

/* rtl/fetchConfig.sv */
// config registers: run bit, reset vector, issue counter, four-phase register bus
`timescale 1ns/100ps
`default_nettype none

module fetchConfig #(
    parameter rvIsaPkg::addrT DefaultResetVector = 32'h0,
    parameter int             CountWidth         = 16
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       cfgReq,
    input  wire                       cfgWrite,
    input  wire fetchCtrlPkg::cfgRegT cfgAddr,
    input  wire [31:0]                cfgWdata,
    input  wire                       issued,
    output logic                      cfgAck,
    output logic [31:0]               cfgRdata,
    output logic                      runEnable,
    output logic                      restart,
    output rvIsaPkg::addrT            resetVector
);

    logic [CountWidth-1:0] fetchCount;
    logic accept;
    logic writeCtrl;

    // first cycle of a request, before ack goes up
    assign accept    = cfgReq && !cfgAck;
    assign writeCtrl = accept && cfgWrite && (cfgAddr == fetchCtrlPkg::RegCtrl);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfgAck      <= 1'b0;
            runEnable   <= 1'b0;
            restart     <= 1'b0;
            resetVector <= DefaultResetVector;
            fetchCount  <= '0;
        end else begin
            cfgAck  <= cfgReq;
            // run 0 -> 1 restarts fetch from the reset vector
            restart <= writeCtrl && cfgWdata[0] && !runEnable;
            if (writeCtrl) begin
                runEnable <= cfgWdata[0];
            end
            if (accept && cfgWrite && cfgAddr == fetchCtrlPkg::RegResetVec) begin
                resetVector <= cfgWdata;
            end
            if (restart) begin
                fetchCount <= '0;
            end else if (issued) begin
                fetchCount <= fetchCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            case (cfgAddr)
                fetchCtrlPkg::RegCtrl:       cfgRdata <= {31'b0, runEnable};
                fetchCtrlPkg::RegResetVec:   cfgRdata <= resetVector;
                fetchCtrlPkg::RegFetchCount: cfgRdata <= 32'(fetchCount);
                default:                     cfgRdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/controlFlowResolver.sv */
// jump and branch target computation for issued control-flow words
`timescale 1ns/100ps
`default_nettype none

module controlFlowResolver (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 restart,
    input  wire                 issued,
    input  wire rvIsaPkg::addrT pc,
    input  wire rvIsaPkg::instT inst,
    input  wire                 resolveValid,
    input  wire                 resolveTaken,
    input  wire rvIsaPkg::addrT rs1Value,
    output logic                enJump,
    output rvIsaPkg::addrT      jumpAddr,
    output logic                enBranch,
    output rvIsaPkg::addrT      branchAddr
);

    fetchCtrlPkg::resolveStateT state;
    rvIsaPkg::opcodeT opIn;
    rvIsaPkg::opcodeT opHeld;
    rvIsaPkg::addrT pcHeld;
    rvIsaPkg::instT instHeld;
    rvIsaPkg::addrT jalrSum;
    logic capture;
    logic resolveNow;

    assign opIn       = rvIsaPkg::opcodeT'(inst[6:0]);
    assign opHeld     = rvIsaPkg::opcodeT'(instHeld[6:0]);
    assign capture    = (state == fetchCtrlPkg::ResIdle) && issued && inst[6];
    assign resolveNow = (state == fetchCtrlPkg::ResNeedExec) && resolveValid;
    assign jalrSum    = rs1Value + rvIsaPkg::immI(instHeld);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= fetchCtrlPkg::ResIdle;
            enJump   <= 1'b0;
            enBranch <= 1'b0;
        end else begin
            enJump   <= 1'b0;
            enBranch <= 1'b0;
            if (restart) begin
                state <= fetchCtrlPkg::ResIdle;
            end else begin
                case (state)
                    fetchCtrlPkg::ResIdle: begin
                        if (capture) begin
                            if (opIn == rvIsaPkg::OpJal) begin
                                enJump <= 1'b1;
                                state  <= fetchCtrlPkg::ResJal;
                            end else begin
                                state <= fetchCtrlPkg::ResNeedExec;
                            end
                        end
                    end
                    // jal target is out on the bus this cycle
                    fetchCtrlPkg::ResJal: begin
                        state <= fetchCtrlPkg::ResIdle;
                    end
                    fetchCtrlPkg::ResNeedExec: begin
                        if (resolveValid) begin
                            if (opHeld == rvIsaPkg::OpJalr) begin
                                enJump <= 1'b1;
                            end else begin
                                enBranch <= 1'b1;
                            end
                            state <= fetchCtrlPkg::ResIdle;
                        end
                    end
                    default: begin
                        state <= fetchCtrlPkg::ResIdle;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            pcHeld   <= pc;
            instHeld <= inst;
            if (opIn == rvIsaPkg::OpJal) begin
                jumpAddr <= pc + rvIsaPkg::immJ(inst);
            end
        end
        if (resolveNow) begin
            if (opHeld == rvIsaPkg::OpJalr) begin
                jumpAddr <= {jalrSum[rvIsaPkg::XLEN-1:1], 1'b0};
            end else begin
                branchAddr <= resolveTaken ? pcHeld + rvIsaPkg::immB(instHeld)
                                           : pcHeld + 32'd4;
            end
        end
    end

    // no new control-flow word before the previous one is resolved
    assert property (@(posedge clk) disable iff (rst)
        (issued && inst[6]) |-> (state == fetchCtrlPkg::ResIdle));

endmodule

`default_nettype wire

/* rtl/instBusBridge.sv */
// request pulse to four-phase req/ack memory transaction, captured word hold
`timescale 1ns/100ps
`default_nettype none

module instBusBridge (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 instEn,
    input  wire rvIsaPkg::addrT instAddr,
    input  wire                 memAck,
    input  wire rvIsaPkg::instT memData,
    output logic                memReq,
    output rvIsaPkg::addrT      memAddr,
    output logic                memInstOutEn,
    output rvIsaPkg::instT      memInst
);

    typedef enum logic [1:0] {
        BrIdle    = 2'd0,
        BrRequest = 2'd1,
        BrAckLow  = 2'd2,
        BrDone    = 2'd3
    } bridgeStateT;

    bridgeStateT state;

    assign memInstOutEn = (state == BrDone);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= BrIdle;
            memReq <= 1'b0;
        end else begin
            case (state)
                BrIdle: begin
                    if (instEn) begin
                        memReq <= 1'b1;
                        state  <= BrRequest;
                    end
                end
                BrRequest: begin
                    if (memAck) begin
                        memReq <= 1'b0;
                        state  <= BrAckLow;
                    end
                end
                // memory must release ack before the word is handed on
                BrAckLow: begin
                    if (!memAck) begin
                        state <= BrDone;
                    end
                end
                default: begin
                    state <= BrIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == BrIdle && instEn) begin
            memAddr <= instAddr;
        end
        if (state == BrRequest && memAck) begin
            memInst <= memData;
        end
    end

    // memory acks only a pending request
    assert property (@(posedge clk) disable iff (rst)
        $rose(memAck) |-> memReq);

endmodule

`default_nettype wire

/* rtl/fetchUnit.sv */
// fetch FSM: memory request, decoder outputs with stall hold, redirect wait
`timescale 1ns/100ps
`default_nettype none

module fetchUnit (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 stall,
    input  wire                 runEnable,
    input  wire                 restart,
    input  wire rvIsaPkg::addrT resetVector,
    input  wire                 enJump,
    input  wire rvIsaPkg::addrT jumpAddr,
    input  wire                 enBranch,
    input  wire rvIsaPkg::addrT branchAddr,
    input  wire                 memInstOutEn,
    input  wire rvIsaPkg::instT memInst,
    output logic                decEn,
    output rvIsaPkg::addrT      pc,
    output rvIsaPkg::instT      inst,
    output logic                issued,
    output logic                instEn,
    output rvIsaPkg::addrT      instAddr
);

    fetchCtrlPkg::fetchStateT state;
    logic loadOut;

    // word goes to the decoder on arrival, or once a stall on arrival clears
    assign loadOut = !stall &&
                     ((state == fetchCtrlPkg::FetchWait && memInstOutEn) ||
                      (state == fetchCtrlPkg::FetchStall && !decEn));

    assign issued = decEn && !stall;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= fetchCtrlPkg::FetchIdle;
            instEn   <= 1'b0;
            instAddr <= '0;
            decEn    <= 1'b0;
        end else begin
            instEn <= 1'b0;
            if (restart) begin
                state    <= fetchCtrlPkg::FetchIdle;
                instAddr <= resetVector;
                decEn    <= 1'b0;
            end else begin
                if (loadOut) begin
                    decEn <= 1'b1;
                end
                case (state)
                    fetchCtrlPkg::FetchIdle: begin
                        if (runEnable) begin
                            instEn <= 1'b1;
                            state  <= fetchCtrlPkg::FetchWait;
                        end
                    end
                    fetchCtrlPkg::FetchWait: begin
                        if (memInstOutEn) begin
                            state <= fetchCtrlPkg::FetchStall;
                        end
                    end
                    // holds the word until the decoder takes it
                    fetchCtrlPkg::FetchStall: begin
                        if (issued) begin
                            decEn <= 1'b0;
                            if (inst[6]) begin
                                state <= fetchCtrlPkg::FetchRedirect;
                            end else begin
                                instAddr <= instAddr + 32'd4;
                                state    <= fetchCtrlPkg::FetchIdle;
                            end
                        end
                    end
                    fetchCtrlPkg::FetchRedirect: begin
                        if (enJump || enBranch) begin
                            instAddr <= enJump ? jumpAddr : branchAddr;
                            if (runEnable) begin
                                instEn <= 1'b1;
                                state  <= fetchCtrlPkg::FetchWait;
                            end else begin
                                // run dropped, park until restarted
                                state <= fetchCtrlPkg::FetchIdle;
                            end
                        end
                    end
                    default: begin
                        state <= fetchCtrlPkg::FetchIdle;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (loadOut) begin
            pc   <= instAddr;
            inst <= memInst;
        end
    end

    // redirect only arrives while a control-flow word waits for it
    assert property (@(posedge clk) disable iff (rst)
        (enJump || enBranch) |-> (state == fetchCtrlPkg::FetchRedirect));

endmodule

`default_nettype wire

/* rtl/fetchCtrlPkg.sv */
// fetch and resolver state enums, config register address map
`default_nettype none

package fetchCtrlPkg;

    typedef enum logic [1:0] {
        FetchIdle     = 2'd0,
        FetchWait     = 2'd1,
        FetchRedirect = 2'd2,
        FetchStall    = 2'd3
    } fetchStateT;

    typedef enum logic [1:0] {
        ResIdle     = 2'd0,
        ResJal      = 2'd1,
        ResNeedExec = 2'd2
    } resolveStateT;

    // config bus register addresses
    typedef enum logic [1:0] {
        RegCtrl       = 2'd0,
        RegResetVec   = 2'd1,
        RegFetchCount = 2'd2
    } cfgRegT;

endpackage

`default_nettype wire

/* rtl/rvIsaPkg.sv */
// RV32I widths, instruction and address types, opcode enum, immediate extraction
`default_nettype none

package rvIsaPkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] instT;
    typedef logic [XLEN-1:0] addrT;

    // major opcodes seen by the front end
    typedef enum logic [6:0] {
        OpJal    = 7'b1101111,
        OpJalr   = 7'b1100111,
        OpBranch = 7'b1100011,
        OpOther  = 7'b0010011
    } opcodeT;

    // J-type, jal offset
    function automatic addrT immJ(input instT i);
        immJ = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
    endfunction

    // B-type, conditional branch offset
    function automatic addrT immB(input instT i);
        immB = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
    endfunction

    // I-type, used by jalr
    function automatic addrT immI(input instT i);
        immI = {{21{i[31]}}, i[30:20]};
    endfunction

endpackage

`default_nettype wire
